// ==== trace_pkg.sv ====
package trace_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned ORDER_W    = 64;
  localparam int unsigned BE_W       = 4;
  localparam int unsigned CINSN_W    = 16;

  ////////////////////
  // Encodings
  ////////////////////

  // LSU access size
  typedef enum logic [1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2,
    DT_NONE = 2'd3
  } data_type_e;

  // Next PC source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // Exception PC source
  // Only EXC and IRQ enter a trap handler
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  ////////////////////
  // Pipeline views
  ////////////////////

  typedef struct packed {
    logic [XLEN-1:0]    rdata;
    logic [CINSN_W-1:0] rdata_c;
    logic               is_compressed;
    logic               illegal;
    logic [XLEN-1:0]    pc_id;
    logic [XLEN-1:0]    pc_if;
  } id_info_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic                  rd_we;
  } reg_info_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] wdata;
    data_type_e      data_type;
    logic            we;
  } mem_info_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_ctrl_t;

  // One record per retired instruction
  typedef struct packed {
    logic                  valid;
    logic [ORDER_W-1:0]    order;
    logic [XLEN-1:0]       insn;
    logic [XLEN-1:0]       insn_uncompressed;
    logic                  trap;
    logic                  halt;
    logic                  intr;
    priv_lvl_e             mode;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [BE_W-1:0]       mem_rmask;
    logic [BE_W-1:0]       mem_wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
  } trace_rec_t;

endpackage

// ==== trace_insn_tracker.sv ====
`timescale 1ns/100ps

module trace_insn_tracker (
  input  logic                clk,
  input  logic                rst_ni,
  input  logic                instr_new_i,
  input  logic                instr_ret_i,
  input  trace_pkg::pc_ctrl_t pc_ctrl_i,
  output logic                insn_new_o,
  output logic                intr_o
);

  import trace_pkg::*;

  logic insn_new_q;
  logic trap_pc_d;
  logic trap_pc_q;
  logic trap_entry;

  // In flight from the decode pulse through the retire cycle
  assign insn_new_o = instr_new_i | insn_new_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_new_q <= 1'b0;
    end else if (instr_ret_i) begin
      insn_new_q <= 1'b0;
    end else begin
      insn_new_q <= insn_new_o;
    end
  end

  ////////////////////
  // Trap entry
  ////////////////////

  // Jump into an exception or interrupt handler but not into debug mode
  assign trap_entry = pc_ctrl_i.pc_set && (pc_ctrl_i.pc_mux == PC_EXC) &&
                      ((pc_ctrl_i.exc_pc_mux == EXC_PC_EXC) ||
                       (pc_ctrl_i.exc_pc_mux == EXC_PC_IRQ));

  always_comb begin
    trap_pc_d = trap_pc_q;
    if (trap_entry) begin
      trap_pc_d = 1'b1;
    end else if (trap_pc_q && instr_ret_i) begin
      // First handler instruction has retired
      trap_pc_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_pc_q <= 1'b0;
    end else begin
      trap_pc_q <= trap_pc_d;
    end
  end

  assign intr_o = trap_pc_q & insn_new_o;

endmodule

// ==== trace_reg_capture.sv ====
`timescale 1ns/100ps

module trace_reg_capture (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  logic                 instr_new_i,
  input  logic                 insn_new_i,
  input  trace_pkg::reg_info_t reg_i,
  output trace_pkg::reg_info_t reg_o
);

  import trace_pkg::*;

  reg_info_t reg_d;
  reg_info_t reg_q;

  always_comb begin
    reg_d = reg_q;

    // Operands as read when decode took the instruction
    if (instr_new_i) begin
      reg_d.rs1_addr = reg_i.rs1_addr;
      reg_d.rs1_data = reg_i.rs1_data;
      reg_d.rs2_addr = reg_i.rs2_addr;
      reg_d.rs2_data = reg_i.rs2_data;
    end

    // Destination follows the register file while in flight
    if (insn_new_i) begin
      if (!reg_i.rd_we) begin
        reg_d.rd_addr  = '0;
        reg_d.rd_wdata = '0;
      end else begin
        reg_d.rd_addr = reg_i.rd_addr;
        if (reg_i.rd_addr == '0) begin
          // x0 is hardwired
          reg_d.rd_wdata = '0;
        end else begin
          reg_d.rd_wdata = reg_i.rd_wdata;
        end
      end
    end

    // Write enable already folded into rd_addr and rd_wdata
    reg_d.rd_we = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_q <= '0;
    end else begin
      reg_q <= reg_d;
    end
  end

  assign reg_o = reg_d;

endmodule

// ==== trace_mem_capture.sv ====
`timescale 1ns/100ps

module trace_mem_capture (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       insn_new_i,
  input  logic                       lsu_data_valid_i,
  input  trace_pkg::mem_info_t       mem_i,
  output trace_pkg::mem_info_t       mem_o,
  output logic [trace_pkg::BE_W-1:0] rmask_o,
  output logic [trace_pkg::BE_W-1:0] wmask_o
);

  import trace_pkg::*;

  mem_info_t mem_d;
  mem_info_t mem_q;

  // Last valid LSU result of the instruction in flight
  always_comb begin
    if (insn_new_i && lsu_data_valid_i) begin
      mem_d = mem_i;
    end else begin
      mem_d = mem_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  assign mem_o = mem_d;

  ////////////////////
  // Byte masks
  ////////////////////

  // Taken from the live access size
  always_comb begin
    unique case (mem_i.data_type)
      DT_WORD: rmask_o = 4'b1111;
      DT_HALF: rmask_o = 4'b0011;
      DT_BYTE: rmask_o = 4'b0001;
      default: rmask_o = 4'b0000;
    endcase
  end

  assign wmask_o = mem_i.we ? rmask_o : '0;

endmodule

// ==== trace_record_reg.sv ====
`timescale 1ns/100ps

module trace_record_reg (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       instr_ret_i,
  input  logic                       intr_i,
  input  trace_pkg::id_info_t        id_i,
  input  trace_pkg::reg_info_t       reg_i,
  input  trace_pkg::mem_info_t       mem_i,
  input  logic [trace_pkg::BE_W-1:0] rmask_i,
  input  logic [trace_pkg::BE_W-1:0] wmask_i,
  output trace_pkg::trace_rec_t      rec_o
);

  import trace_pkg::*;

  trace_rec_t      rec_d;
  logic [XLEN-1:0] insn;

  // Compressed encodings are reported zero-extended
  always_comb begin
    if (id_i.is_compressed) begin
      insn = {{(XLEN-CINSN_W){1'b0}}, id_i.rdata_c};
    end else begin
      insn = id_i.rdata;
    end
  end

  ////////////////////
  // Record fields
  ////////////////////

  always_comb begin
    rec_d.valid             = instr_ret_i;
    // Count advances after each valid record
    rec_d.order             = rec_o.order + ORDER_W'(rec_o.valid);
    rec_d.insn              = insn;
    rec_d.insn_uncompressed = id_i.rdata;
    rec_d.trap              = id_i.illegal;
    rec_d.halt              = 1'b0;
    rec_d.intr              = intr_i;
    // Machine mode only
    rec_d.mode              = PRIV_LVL_M;
    rec_d.rs1_addr          = reg_i.rs1_addr;
    rec_d.rs2_addr          = reg_i.rs2_addr;
    rec_d.rs1_rdata         = reg_i.rs1_data;
    rec_d.rs2_rdata         = reg_i.rs2_data;
    rec_d.rd_addr           = reg_i.rd_addr;
    rec_d.rd_wdata          = reg_i.rd_wdata;
    rec_d.pc_rdata          = id_i.pc_id;
    rec_d.pc_wdata          = id_i.pc_if;
    rec_d.mem_addr          = mem_i.addr;
    rec_d.mem_rmask         = rmask_i;
    rec_d.mem_wmask         = wmask_i;
    rec_d.mem_rdata         = mem_i.rdata;
    rec_d.mem_wdata         = mem_i.wdata;
  end

  // Output stage
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_o <= '0;
    end else begin
      rec_o <= rec_d;
    end
  end

endmodule

// ==== trace_unit_top.sv ====
`timescale 1ns/100ps

module trace_unit_top (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  instr_new_i,
  input  logic                  instr_ret_i,
  input  logic                  lsu_data_valid_i,
  input  trace_pkg::id_info_t   id_i,
  input  trace_pkg::reg_info_t  reg_i,
  input  trace_pkg::mem_info_t  mem_i,
  input  trace_pkg::pc_ctrl_t   pc_ctrl_i,
  output trace_pkg::trace_rec_t rec_o
);

  import trace_pkg::*;

  logic            insn_new;
  logic            intr_d;
  reg_info_t       reg_held;
  mem_info_t       mem_held;
  logic [BE_W-1:0] rmask;
  logic [BE_W-1:0] wmask;

  trace_insn_tracker u_insn_tracker (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_new_i (instr_new_i),
    .instr_ret_i (instr_ret_i),
    .pc_ctrl_i   (pc_ctrl_i),
    .insn_new_o  (insn_new),
    .intr_o      (intr_d)
  );

  trace_reg_capture u_reg_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_new_i (instr_new_i),
    .insn_new_i  (insn_new),
    .reg_i       (reg_i),
    .reg_o       (reg_held)
  );

  trace_mem_capture u_mem_capture (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .insn_new_i       (insn_new),
    .lsu_data_valid_i (lsu_data_valid_i),
    .mem_i            (mem_i),
    .mem_o            (mem_held),
    .rmask_o          (rmask),
    .wmask_o          (wmask)
  );

  trace_record_reg u_record_reg (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_ret_i (instr_ret_i),
    .intr_i      (intr_d),
    .id_i        (id_i),
    .reg_i       (reg_held),
    .mem_i       (mem_held),
    .rmask_i     (rmask),
    .wmask_i     (wmask),
    .rec_o       (rec_o)
  );

endmodule

// ==== trace_unit_assertions.sv ====
`timescale 1ns/100ps

module trace_unit_assertions (
  input logic                  clk,
  input logic                  rst_ni,
  input trace_pkg::trace_rec_t rec_o
);

  import trace_pkg::*;

  // Never two records in a row
  valid_single: assert property (@(posedge clk) disable iff (!rst_ni)
    rec_o.valid |=> !rec_o.valid)
    else $error("rec_o.valid high in two consecutive cycles");

  halt_zero: assert property (@(posedge clk) disable iff (!rst_ni) !rec_o.halt)
    else $error("rec_o.halt is set");

  // Machine mode on every record
  mode_m: assert property (@(posedge clk) disable iff (!rst_ni)
    rec_o.valid |-> (rec_o.mode == PRIV_LVL_M))
    else $error("rec_o.mode is not machine mode");

  wmask_rmask: assert property (@(posedge clk) disable iff (!rst_ni)
    (rec_o.mem_wmask != '0) |-> (rec_o.mem_wmask == rec_o.mem_rmask))
    else $error("rec_o.mem_wmask differs from rec_o.mem_rmask");

endmodule

bind trace_unit_top trace_unit_assertions u_assertions (
  .clk    (clk),
  .rst_ni (rst_ni),
  .rec_o  (rec_o)
);

// ==== tb_trace_unit.sv ====
`timescale 1ns/100ps

module tb_trace_unit;

  import trace_pkg::*;

  localparam int N_TESTS = 46;
  localparam int RST_CYC = 16;
  localparam int MAX_CYC = 40 * N_TESTS + RST_CYC;

  // Shape of one transaction
  typedef struct packed {
    logic       rd_we;
    logic       rd_x0;
    logic       lsu;
    data_type_e dt;
    logic       we;
    logic       compressed;
    logic       trap;
  } txn_opt_t;

  logic       clk;
  logic       rst_ni;
  logic       instr_new_i;
  logic       instr_ret_i;
  logic       lsu_data_valid_i;
  id_info_t   id_i;
  reg_info_t  reg_i;
  mem_info_t  mem_i;
  pc_ctrl_t   pc_ctrl_i;
  trace_rec_t rec_o;

  trace_rec_t exp_q[$];
  string      name_q[$];
  mem_info_t  mem_model;
  int         err_cnt = 0;
  int         n_sent = 0;
  int         n_checked = 0;
  int         cyc = 0;
  logic       ret_seen = 1'b0;

  trace_unit_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Retire strobe as seen by the record register and the run limit
  always @(posedge clk) begin
    ret_seen <= instr_ret_i;
    cyc <= cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("Timeout: no result after %0d cycles", MAX_CYC);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic reg_info_t rand_reg(logic we, logic x0);
    reg_info_t r;
    r.rs1_addr = REG_ADDR_W'($urandom);
    r.rs1_data = $urandom;
    r.rs2_addr = REG_ADDR_W'($urandom);
    r.rs2_data = $urandom;
    r.rd_addr  = x0 ? '0 : REG_ADDR_W'($urandom_range(1, 31));
    r.rd_wdata = $urandom;
    r.rd_we    = we;
    return r;
  endfunction

  function automatic mem_info_t rand_mem(data_type_e dt, logic we);
    mem_info_t m;
    m.addr      = $urandom;
    m.rdata     = $urandom;
    m.wdata     = $urandom;
    m.data_type = dt;
    m.we        = we;
    return m;
  endfunction

  function automatic id_info_t rand_id(logic compressed);
    id_info_t d;
    d.rdata         = $urandom;
    d.rdata_c       = CINSN_W'($urandom);
    d.is_compressed = compressed;
    d.illegal       = ($urandom_range(0, 7) == 0);
    d.pc_id         = $urandom;
    d.pc_if         = $urandom;
    return d;
  endfunction

  // Expected record for one instruction
  function automatic trace_rec_t ref_rec(reg_info_t reg_new, reg_info_t reg_ret,
                                         mem_info_t mem_held, mem_info_t mem_ret,
                                         id_info_t id_ret, logic intr);
    trace_rec_t r;
    logic [BE_W-1:0] rmask;
    case (mem_ret.data_type)
      DT_WORD: rmask = 4'b1111;
      DT_HALF: rmask = 4'b0011;
      DT_BYTE: rmask = 4'b0001;
      default: rmask = 4'b0000;
    endcase
    r                   = '0;
    r.valid             = 1'b1;
    r.insn              = id_ret.is_compressed ? {16'h0, id_ret.rdata_c} : id_ret.rdata;
    r.insn_uncompressed = id_ret.rdata;
    r.trap              = id_ret.illegal;
    r.intr              = intr;
    r.mode              = PRIV_LVL_M;
    r.rs1_addr          = reg_new.rs1_addr;
    r.rs2_addr          = reg_new.rs2_addr;
    r.rs1_rdata         = reg_new.rs1_data;
    r.rs2_rdata         = reg_new.rs2_data;
    if (reg_ret.rd_we) begin
      r.rd_addr  = reg_ret.rd_addr;
      r.rd_wdata = (reg_ret.rd_addr == '0) ? '0 : reg_ret.rd_wdata;
    end
    r.pc_rdata  = id_ret.pc_id;
    r.pc_wdata  = id_ret.pc_if;
    r.mem_addr  = mem_held.addr;
    r.mem_rdata = mem_held.rdata;
    r.mem_wdata = mem_held.wdata;
    r.mem_rmask = rmask;
    r.mem_wmask = mem_ret.we ? rmask : '0;
    return r;
  endfunction

  task automatic drive_cycle(logic new_p, logic ret_p, logic lsu_v, reg_info_t r,
                             mem_info_t m, id_info_t d, pc_ctrl_t pc);
    @(negedge clk);
    instr_new_i      = new_p;
    instr_ret_i      = ret_p;
    lsu_data_valid_i = lsu_v;
    reg_i            = r;
    mem_i            = m;
    id_i             = d;
    pc_ctrl_i        = pc;
  endtask

  task automatic run_txn(string name, txn_opt_t opt);
    reg_info_t reg_new;
    reg_info_t reg_ret;
    mem_info_t mem_ret;
    id_info_t  id_ret;
    pc_ctrl_t  pc;
    int        gap;
    int        lsu_cyc;
    gap     = $urandom_range(0, 3);
    lsu_cyc = opt.lsu ? $urandom_range(1, 2) : 0;
    pc      = '0;
    if (opt.trap) begin
      pc.pc_set     = 1'b1;
      pc.pc_mux     = PC_EXC;
      pc.exc_pc_mux = ($urandom_range(0, 1) == 0) ? EXC_PC_EXC : EXC_PC_IRQ;
      drive_cycle(1'b0, 1'b0, 1'b0, rand_reg(1'b1, 1'b0), rand_mem(DT_NONE, 1'b0),
                  rand_id(1'b0), pc);
      pc = '0;
    end
    reg_new = rand_reg(1'b1, 1'b0);
    drive_cycle(1'b1, 1'b0, 1'b0, reg_new, rand_mem(opt.dt, opt.we), rand_id(1'b0), pc);
    // Operands keep changing while the instruction is in flight
    repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, rand_reg(1'($urandom), 1'b0),
                             rand_mem(opt.dt, opt.we), rand_id(1'b0), pc);
    repeat (lsu_cyc) begin
      mem_model = rand_mem(opt.dt, opt.we);
      drive_cycle(1'b0, 1'b0, 1'b1, rand_reg(1'b1, 1'b0), mem_model, rand_id(1'b0), pc);
    end
    reg_ret = rand_reg(opt.rd_we, opt.rd_x0);
    mem_ret = rand_mem(opt.dt, opt.we);
    id_ret  = rand_id(opt.compressed);
    drive_cycle(1'b0, 1'b1, 1'b0, reg_ret, mem_ret, id_ret, pc);
    exp_q.push_back(ref_rec(reg_new, reg_ret, mem_model, mem_ret, id_ret, opt.trap));
    name_q.push_back(name);
    n_sent++;
    drive_cycle(1'b0, 1'b0, 1'b0, rand_reg(1'b1, 1'b0), rand_mem(DT_NONE, 1'b0),
                rand_id(1'b0), pc);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_rec(trace_rec_t exp_rec, trace_rec_t got);
    trace_rec_t e;
    trace_rec_t g;
    e       = exp_rec;
    g       = got;
    e.order = '0;
    g.order = '0;
    if (g !== e) begin
      $display("FAILED rec_o: expected %h got %h", e, g);
      err_cnt++;
    end
  endtask

  task automatic check_order(logic [ORDER_W-1:0] exp_ord, logic [ORDER_W-1:0] got);
    if (got !== exp_ord) begin
      $display("FAILED rec_o.order: expected %h got %h", exp_ord, got);
      err_cnt++;
    end
  endtask

  initial begin
    int         err_before;
    trace_rec_t exp_rec;
    // Record must be cleared in the last reset cycle
    repeat (RST_CYC - 1) @(negedge clk);
    err_before = err_cnt;
    check_rec('0, rec_o);
    check_order('0, rec_o.order);
    $display("test 0 reset: %s", (err_cnt == err_before) ? "pass" : "fail");
    forever begin
      @(negedge clk);
      if (rec_o.valid !== ret_seen) begin
        $display("Record valid did not follow instr_ret_i by exactly one cycle");
        err_cnt++;
      end
      if (rec_o.valid === 1'b1 && exp_q.size() == 0) begin
        $display("Record appeared with no instruction retired");
        err_cnt++;
      end else if (rec_o.valid === 1'b1) begin
        err_before = err_cnt;
        exp_rec    = exp_q.pop_front();
        check_rec(exp_rec, rec_o);
        check_order(ORDER_W'(n_checked), rec_o.order);
        n_checked++;
        $display("test %0d %s: %s", n_checked, name_q.pop_front(),
                 (err_cnt == err_before) ? "pass" : "fail");
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    txn_opt_t opt;
    int       i;
    void'($urandom(32'hac2));
    rst_ni           = 1'b0;
    instr_new_i      = 1'b0;
    instr_ret_i      = 1'b0;
    lsu_data_valid_i = 1'b0;
    id_i             = '0;
    reg_i            = '0;
    mem_i            = '0;
    pc_ctrl_i        = '0;
    mem_model        = '0;
    repeat (RST_CYC) @(negedge clk);
    rst_ni = 1'b1;

    opt       = '0;
    opt.rd_we = 1'b1;
    opt.dt    = DT_NONE;
    repeat (3) run_txn("alu", opt);
    opt.rd_we = 1'b0;
    run_txn("rd_we_low", opt);
    opt.rd_we = 1'b1;
    opt.rd_x0 = 1'b1;
    run_txn("rd_x0", opt);
    opt.rd_x0 = 1'b0;
    opt.lsu   = 1'b1;
    // Load then store for word, half and byte
    for (i = 0; i < 6; i++) begin
      opt.dt = data_type_e'(2'(i / 2));
      opt.we = 1'(i % 2);
      run_txn(opt.we ? "store" : "load", opt);
    end
    opt.lsu        = 1'b0;
    opt.we         = 1'b0;
    opt.dt         = DT_NONE;
    opt.compressed = 1'b1;
    repeat (2) run_txn("compressed", opt);
    opt.compressed = 1'b0;
    opt.trap       = 1'b1;
    run_txn("trap_entry", opt);
    opt.trap = 1'b0;
    run_txn("after_trap", opt);
    repeat (30) begin
      opt.rd_we      = 1'($urandom);
      opt.rd_x0      = ($urandom_range(0, 7) == 0);
      opt.lsu        = 1'($urandom);
      opt.dt         = data_type_e'(2'($urandom));
      opt.we         = 1'($urandom);
      opt.compressed = 1'($urandom);
      opt.trap       = ($urandom_range(0, 4) == 0);
      run_txn("random", opt);
    end

    wait (n_checked == n_sent);
    repeat (2) @(negedge clk);
    $display("Tests: %0d, errors: %0d", n_checked + 1, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
trace_pkg.sv
trace_insn_tracker.sv
trace_reg_capture.sv
trace_mem_capture.sv
trace_record_reg.sv
trace_unit_top.sv
trace_unit_assertions.sv
tb_trace_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_trace_unit
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -q "Done: no errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
